// File: hw/mpmc_consts.svh
`ifndef MPMC_CONSTS_SVH
`define MPMC_CONSTS_SVH

// ==============================
// Burst engine widths
// ==============================

// One strip is the data moved by a single memory command
`define MPMC_STRIP_W 32

// Strip counts and strip indexes share this width
// A burst therefore carries at most eight strips
`define MPMC_NSTRIP_W 3

// A cache line is eight strips wide
`define MPMC_LINE_W 256

// Strip address as seen by the memory port
// The package splits it into row, bank and column
`define MPMC_ADDR_W 28

`endif

// File: hw/mpmc_pkg.sv
`default_nettype none

`include "mpmc_consts.svh"

package mpmc_pkg;

	// ==============================
	// Burst sequencing
	// ==============================

	// States of the line-burst FSM
	// Reads pass through READ_DATA1 while the last responses drain
	typedef enum logic [3:0] {
		IDLE        = 4'd0,
		PRESET      = 4'd1,
		READ_DATA0  = 4'd2,
		READ_DATA1  = 4'd3,
		WRITE_DATA0 = 4'd4,
		DONE        = 4'd5
	} burst_state_t;

	// ==============================
	// Memory address
	// ==============================

	// Field types of the split address, shared with the memory port
	typedef logic [13:0] mem_row_t;
	typedef logic [2:0]  mem_bank_t;
	typedef logic [10:0] mem_col_t;

	// Row sits on top and the column at the bottom, so strips step the column
	typedef struct packed {
		mem_row_t  row;
		mem_bank_t bank;
		mem_col_t  col;
	} mem_split_t;

	// The same strip address read either as one word or as its fields
	typedef union packed {
		logic [`MPMC_ADDR_W-1:0] flat;
		mem_split_t              split;
	} mem_addr_t;

endpackage

`default_nettype wire

// File: hw/mpmc_burst_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_burst_fsm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req,
	input  logic                   we,
	input  logic                   last_cmd,
	input  logic                   mem_ready,
	input  logic                   last_strip,
	output mpmc_pkg::burst_state_t state,
	output logic                   busy,
	output logic                   done,
	output logic                   mem_cmd,
	output logic                   mem_we
);

	mpmc_pkg::burst_state_t state_nxt;

	// A command transfers in any cycle where it is offered and the port is ready
	logic xfer;

	assign xfer = mem_cmd && mem_ready;

	// ==============================
	// Next state
	// ==============================

	always_comb begin
		state_nxt = state;
		case (state)
			mpmc_pkg::IDLE: begin
				// Only an idle engine takes a request
				// Busy turns it away otherwise
				if (req)
					state_nxt = mpmc_pkg::PRESET;
			end
			mpmc_pkg::PRESET: begin
				// The request fields are sampled here by every block
				if (we)
					state_nxt = mpmc_pkg::WRITE_DATA0;
				else
					state_nxt = mpmc_pkg::READ_DATA0;
			end
			mpmc_pkg::WRITE_DATA0: begin
				// Writes are finished once the final strip leaves
				if (xfer && last_cmd)
					state_nxt = mpmc_pkg::DONE;
			end
			mpmc_pkg::READ_DATA0: begin
				// Leave once the final read command is out while responses may still be pending
				if (xfer && last_cmd)
					state_nxt = mpmc_pkg::READ_DATA1;
			end
			mpmc_pkg::READ_DATA1: begin
				// Wait for the response counter to see the final strip
				if (last_strip)
					state_nxt = mpmc_pkg::DONE;
			end
			mpmc_pkg::DONE: begin
				state_nxt = mpmc_pkg::IDLE;
			end
			default: begin
				state_nxt = mpmc_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= mpmc_pkg::IDLE;
		else
			state <= state_nxt;
	end

	// Direction of the burst is taken once and held for every command
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_we <= 1'b0;
		else if (state == mpmc_pkg::PRESET)
			mem_we <= we;
	end

	// ==============================
	// Outputs decoded from state
	// ==============================

	// Busy covers PRESET through DONE, so a request in DONE is also ignored
	assign busy = (state != mpmc_pkg::IDLE);
	assign done = (state == mpmc_pkg::DONE);

	// One command is offered in every cycle of the issue states
	assign mem_cmd = (state == mpmc_pkg::READ_DATA0) || (state == mpmc_pkg::WRITE_DATA0);

	// The final read strip only counts while the FSM is waiting for it
	a_last_strip_wait: assert property (@(posedge clk) disable iff (!rst_n)
		last_strip |-> (state == mpmc_pkg::READ_DATA1));

	// A stalled command keeps the request counter where it is
	a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_cmd && !mem_ready |=> $stable(last_cmd));

endmodule

`default_nettype wire

// File: hw/mpmc_req_strip_cnt.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_req_strip_cnt (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mpmc_pkg::burst_state_t    state,
	input  logic [`MPMC_ADDR_W-1:0]   line_addr,
	input  logic [`MPMC_NSTRIP_W-1:0] num_strips,
	input  logic                      mem_ready,
	output logic [`MPMC_NSTRIP_W-1:0] cmd_idx,
	output logic                      last_cmd,
	output mpmc_pkg::mem_bank_t       mem_bank,
	output mpmc_pkg::mem_row_t        mem_row,
	output mpmc_pkg::mem_col_t        mem_col
);

	mpmc_pkg::mem_addr_t       base_q;
	mpmc_pkg::mem_addr_t       cur_addr;
	logic [`MPMC_NSTRIP_W-1:0] num_q;
	logic                      xfer;

	// Commands only move in the two issue states
	assign xfer = mem_ready &&
		((state == mpmc_pkg::READ_DATA0) || (state == mpmc_pkg::WRITE_DATA0));

	// Index of the strip being offered
	// It stops on the final strip so the FSM can leave on that transfer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_idx <= '0;
			num_q   <= '0;
		end else if (state == mpmc_pkg::PRESET) begin
			cmd_idx <= '0;
			num_q   <= num_strips;
		end else if (xfer && !last_cmd) begin
			cmd_idx <= cmd_idx + `MPMC_NSTRIP_W'(1);
		end
	end

	assign last_cmd = (cmd_idx == num_q);

	// Line address is written through the flat view
	always_ff @(posedge clk) begin
		if (state == mpmc_pkg::PRESET)
			base_q.flat <= line_addr;
	end

	// Row and bank come straight from the line while the column walks with the index
	always_comb begin
		cur_addr           = base_q;
		cur_addr.split.col = base_q.split.col + mpmc_pkg::mem_col_t'(cmd_idx);
	end

	assign mem_bank = cur_addr.split.bank;
	assign mem_row  = cur_addr.split.row;
	assign mem_col  = cur_addr.split.col;

	// Issue ends on the transfer of the final strip so no strip goes out twice
	a_issue_ends: assert property (@(posedge clk) disable iff (!rst_n)
		xfer && last_cmd
		|=> (state != mpmc_pkg::READ_DATA0) && (state != mpmc_pkg::WRITE_DATA0));

endmodule

`default_nettype wire

// File: hw/mpmc_resp_strip_cnt.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_resp_strip_cnt (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mpmc_pkg::burst_state_t    state,
	input  logic                      valid,
	input  logic [`MPMC_NSTRIP_W-1:0] num_strips,
	output logic [`MPMC_NSTRIP_W-1:0] strip_cnt,
	output logic                      last_strip
);

	// Set while read responses are expected
	logic                      armed;
	logic [`MPMC_NSTRIP_W-1:0] num_q;

	// Responses come back in command order, so a plain count names the slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			strip_cnt <= '0;
			armed     <= 1'b0;
			num_q     <= '0;
		end else if (state == mpmc_pkg::IDLE) begin
			strip_cnt <= '0;
			armed     <= 1'b0;
		end else begin
			// The count is kept privately, the client may change it once busy is up
			if (state == mpmc_pkg::PRESET)
				num_q <= num_strips;
			if (state == mpmc_pkg::READ_DATA0)
				armed <= 1'b1;
			// Disarm on the final strip, this overrides the arm above
			if (valid && armed) begin
				if (strip_cnt != num_q)
					strip_cnt <= strip_cnt + `MPMC_NSTRIP_W'(1);
				else
					armed <= 1'b0;
			end
		end
	end

	// High only during the pulse carrying the final strip
	assign last_strip = valid && armed && (strip_cnt == num_q);

	// Memory must not return data that no read command asked for
	a_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
		valid && (state != mpmc_pkg::IDLE) |-> armed);

endmodule

`default_nettype wire

// File: hw/mpmc_line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_line_buffer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mpmc_pkg::burst_state_t    state,
	input  logic [`MPMC_LINE_W-1:0]   wline,
	input  logic [`MPMC_NSTRIP_W-1:0] cmd_idx,
	input  logic                      mem_rd_valid,
	input  logic [`MPMC_STRIP_W-1:0]  mem_rd_data,
	input  logic [`MPMC_NSTRIP_W-1:0] strip_cnt,
	output logic [`MPMC_STRIP_W-1:0]  mem_wdata,
	output logic [`MPMC_LINE_W-1:0]   rline
);

	localparam int NSTRIP = 1 << `MPMC_NSTRIP_W;

	// ==============================
	// Write side
	// ==============================

	// Line to be written, viewed as strips so the index picks one directly
	logic [NSTRIP-1:0][`MPMC_STRIP_W-1:0] wbuf_q;

	always_ff @(posedge clk) begin
		if (state == mpmc_pkg::PRESET)
			wbuf_q <= wline;
	end

	// The strip follows the index, so it stays put while the port stalls
	assign mem_wdata = wbuf_q[cmd_idx];

	// ==============================
	// Read side
	// ==============================

	// Returning strips land in their own slot as they arrive
	// Write bursts never touch this register
	logic [NSTRIP-1:0][`MPMC_STRIP_W-1:0] rbuf_q;

	always_ff @(posedge clk) begin
		if (mem_rd_valid)
			rbuf_q[strip_cnt] <= mem_rd_data;
	end

	assign rline = rbuf_q;

	// Read data may only arrive while a read burst is open
	// In particular the line is never written while idle
	a_rd_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rd_valid |-> (state == mpmc_pkg::READ_DATA0) || (state == mpmc_pkg::READ_DATA1));

endmodule

`default_nettype wire

// File: hw/mpmc_burst_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_burst_engine (
	input  logic                      clk,
	input  logic                      rst_n,
	// Client port
	input  logic                      req,
	input  logic                      we,
	input  logic [`MPMC_ADDR_W-1:0]   line_addr,
	input  logic [`MPMC_NSTRIP_W-1:0] num_strips,
	input  logic [`MPMC_LINE_W-1:0]   wline,
	output logic                      busy,
	output logic                      done,
	output logic [`MPMC_LINE_W-1:0]   rline,
	// Memory port
	output logic                      mem_cmd,
	output logic                      mem_we,
	output mpmc_pkg::mem_bank_t       mem_bank,
	output mpmc_pkg::mem_row_t        mem_row,
	output mpmc_pkg::mem_col_t        mem_col,
	output logic [`MPMC_STRIP_W-1:0]  mem_wdata,
	input  logic                      mem_ready,
	input  logic                      mem_rd_valid,
	input  logic [`MPMC_STRIP_W-1:0]  mem_rd_data
);

	// Burst state is shared by every block
	mpmc_pkg::burst_state_t    state;
	logic [`MPMC_NSTRIP_W-1:0] cmd_idx;
	logic                      last_cmd;
	logic [`MPMC_NSTRIP_W-1:0] strip_cnt;
	logic                      last_strip;

	// Sequencing and the command strobe
	mpmc_burst_fsm u_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.we         (we),
		.last_cmd   (last_cmd),
		.mem_ready  (mem_ready),
		.last_strip (last_strip),
		.state      (state),
		.busy       (busy),
		.done       (done),
		.mem_cmd    (mem_cmd),
		.mem_we     (mem_we)
	);

	// Outgoing strip index and address
	mpmc_req_strip_cnt u_req_cnt (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.line_addr  (line_addr),
		.num_strips (num_strips),
		.mem_ready  (mem_ready),
		.cmd_idx    (cmd_idx),
		.last_cmd   (last_cmd),
		.mem_bank   (mem_bank),
		.mem_row    (mem_row),
		.mem_col    (mem_col)
	);

	// Incoming strip index
	mpmc_resp_strip_cnt u_resp_cnt (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.valid      (mem_rd_valid),
		.num_strips (num_strips),
		.strip_cnt  (strip_cnt),
		.last_strip (last_strip)
	);

	// Line data in both directions
	mpmc_line_buffer u_line_buf (
		.clk          (clk),
		.rst_n        (rst_n),
		.state        (state),
		.wline        (wline),
		.cmd_idx      (cmd_idx),
		.mem_rd_valid (mem_rd_valid),
		.mem_rd_data  (mem_rd_data),
		.strip_cnt    (strip_cnt),
		.mem_wdata    (mem_wdata),
		.rline        (rline)
	);

endmodule

`default_nettype wire

// File: verification/tb_mpmc_burst_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpmc_consts.svh"

module tb_mpmc_burst_engine;

	localparam int NUM_TESTS      = 6;
	localparam int TIMEOUT_CYCLES = 200 * NUM_TESTS;

	// Line addresses written as {row, bank, col}
	localparam logic [`MPMC_ADDR_W-1:0] ADDR_A = {14'h2a51, 3'd3, 11'h040};
	localparam logic [`MPMC_ADDR_W-1:0] ADDR_B = {14'h3001, 3'd7, 11'h7f0};
	localparam logic [`MPMC_ADDR_W-1:0] ADDR_C = {14'h0777, 3'd2, 11'h010};
	localparam logic [`MPMC_ADDR_W-1:0] ADDR_D = {14'h1b3d, 3'd5, 11'h208};
	localparam logic [31:0]             LINE_SEED = 32'hc0de_f00d;

	logic                      clk;
	logic                      rst_n;
	logic                      req;
	logic                      we;
	logic [`MPMC_ADDR_W-1:0]   line_addr;
	logic [`MPMC_NSTRIP_W-1:0] num_strips;
	logic [`MPMC_LINE_W-1:0]   wline;
	logic                      busy;
	logic                      done;
	logic [`MPMC_LINE_W-1:0]   rline;
	logic                      mem_cmd;
	logic                      mem_we;
	logic [2:0]                mem_bank;
	logic [13:0]               mem_row;
	logic [10:0]               mem_col;
	logic [`MPMC_STRIP_W-1:0]  mem_wdata;
	logic                      mem_ready;
	logic                      mem_rd_valid;
	logic [`MPMC_STRIP_W-1:0]  mem_rd_data;

	// Memory model storage keyed by {row, bank, col}
	logic [31:0] store [logic [`MPMC_ADDR_W-1:0]];
	// Every transfer seen on the memory port in order
	logic [`MPMC_ADDR_W-1:0] log_addr [$];
	logic [31:0]             log_data [$];
	logic                    log_we [$];
	// Read responses waiting for their cycle
	int unsigned resp_due [$];
	logic [31:0] resp_data [$];
	int unsigned model_cycle;
	int unsigned last_due;
	int          cmd_count;
	int          done_count;
	logic        stall_en;
	logic [31:0] lfsr;
	int          error_count;
	int          watchdog_cycles;

	mpmc_burst_engine u_mpmc_burst_engine (
		.clk          (clk),
		.rst_n        (rst_n),
		.req          (req),
		.we           (we),
		.line_addr    (line_addr),
		.num_strips   (num_strips),
		.wline        (wline),
		.busy         (busy),
		.done         (done),
		.rline        (rline),
		.mem_cmd      (mem_cmd),
		.mem_we       (mem_we),
		.mem_bank     (mem_bank),
		.mem_row      (mem_row),
		.mem_col      (mem_col),
		.mem_wdata    (mem_wdata),
		.mem_ready    (mem_ready),
		.mem_rd_valid (mem_rd_valid),
		.mem_rd_data  (mem_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==============================
	// Reference rules
	// ==============================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit with the newest bit at the bottom
	task automatic draw_bits(input int n, output logic [7:0] bits);
		int k;
		bits = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[6:0], lfsr[0]};
		end
	endtask

	// Row and bank stay while the column steps with the strip and wraps in 11 bits
	function automatic logic [`MPMC_ADDR_W-1:0] strip_addr(input logic [`MPMC_ADDR_W-1:0] base,
		input int idx);
		logic [10:0] col;
		col = base[10:0] + idx[10:0];
		strip_addr = {base[27:11], col};
	endfunction

	// Content of a location that was never written
	function automatic logic [31:0] fill_word(input logic [`MPMC_ADDR_W-1:0] flat);
		fill_word = {4'h0, flat} ^ 32'h5a5a_a5a5;
	endfunction

	function automatic logic [31:0] read_word(input logic [`MPMC_ADDR_W-1:0] flat);
		if (store.exists(flat))
			read_word = store[flat];
		else
			read_word = fill_word(flat);
	endfunction

	// Write line with a distinct word in each strip
	function automatic logic [`MPMC_LINE_W-1:0] make_line(input logic [31:0] seed);
		int k;
		make_line = '0;
		for (k = 0; k < 8; k++)
			make_line[k*32 +: 32] = seed ^ (32'h0f1e_2d3c * (k + 1));
	endfunction

	// ==============================
	// Memory model
	// ==============================

	// Sampled on the rising edge like a register and replies in command order
	always @(posedge clk) begin : memory_model
		logic [`MPMC_ADDR_W-1:0] addr;
		logic [7:0]              bits;
		int unsigned             lat;
		int unsigned             due;
		if (!rst_n) begin
			mem_rd_valid <= 1'b0;
			mem_rd_data  <= '0;
			mem_ready    <= 1'b1;
			resp_due.delete();
			resp_data.delete();
			model_cycle = 0;
			last_due    = 0;
		end else begin
			model_cycle = model_cycle + 1;
			if (mem_cmd && mem_ready) begin
				addr      = {mem_row, mem_bank, mem_col};
				cmd_count = cmd_count + 1;
				log_addr.push_back(addr);
				log_data.push_back(mem_wdata);
				log_we.push_back(mem_we);
				if (mem_we) begin
					store[addr] = mem_wdata;
				end else begin
					// Latency of 1 to 8 cycles is pushed back so replies never overlap
					draw_bits(3, bits);
					lat = 32'(bits[2:0]) + 1;
					due = model_cycle + lat - 1;
					if (due <= last_due)
						due = last_due + 1;
					last_due = due;
					resp_due.push_back(due);
					resp_data.push_back(read_word(addr));
				end
			end
			if (resp_due.size() > 0 && resp_due[0] <= model_cycle) begin
				mem_rd_valid <= 1'b1;
				mem_rd_data  <= resp_data[0];
				void'(resp_due.pop_front());
				void'(resp_data.pop_front());
			end else begin
				mem_rd_valid <= 1'b0;
			end
			if (done)
				done_count = done_count + 1;
			if (stall_en) begin
				draw_bits(1, bits);
				mem_ready <= bits[0];
			end else begin
				mem_ready <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		watchdog_cycles = watchdog_cycles + 1;
		if (watchdog_cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ==============================
	// Test helpers
	// ==============================

	task automatic report_mismatch(input string test, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		error_count = error_count + 1;
		$display("[FAIL] %s: %s expected %h actual %h", test, what, exp, act);
	endtask

	// Called only while the engine is idle
	task automatic clear_model_log;
		cmd_count  = 0;
		done_count = 0;
		log_addr.delete();
		log_data.delete();
		log_we.delete();
	endtask

	// Fields stay on the bus after the pulse because PRESET samples them a cycle later
	task automatic issue_req(input logic w, input logic [`MPMC_ADDR_W-1:0] addr,
		input logic [`MPMC_NSTRIP_W-1:0] n, input logic [`MPMC_LINE_W-1:0] line);
		@(posedge clk);
		req        <= 1'b1;
		we         <= w;
		line_addr  <= addr;
		num_strips <= n;
		wline      <= line;
		@(posedge clk);
		req <= 1'b0;
	endtask

	// Returns on the falling edge after done once the model has settled
	task automatic wait_done;
		@(posedge clk);
		while (done !== 1'b1)
			@(posedge clk);
		@(negedge clk);
	endtask

	// Checks count and order of read commands and the strips that came back
	task automatic check_read(input string test, input logic [`MPMC_ADDR_W-1:0] base, input int n,
		input logic [`MPMC_LINE_W-1:0] exp_line);
		int k;
		if (cmd_count != n)
			report_mismatch(test, "command count", n, cmd_count);
		for (k = 0; k < n && k < log_addr.size(); k++) begin
			if (log_addr[k] !== strip_addr(base, k))
				report_mismatch(test, "address", {4'h0, strip_addr(base, k)}, {4'h0, log_addr[k]});
			if (log_we[k] !== 1'b0)
				report_mismatch(test, "mem_we", 32'd0, {31'd0, log_we[k]});
			if (rline[k*32 +: 32] !== exp_line[k*32 +: 32])
				report_mismatch(test, "rline strip", exp_line[k*32 +: 32], rline[k*32 +: 32]);
		end
	endtask

	// Expected line for a location set that was never written
	function automatic logic [`MPMC_LINE_W-1:0] fill_line(input logic [`MPMC_ADDR_W-1:0] base);
		int k;
		fill_line = '0;
		for (k = 0; k < 8; k++)
			fill_line[k*32 +: 32] = fill_word(strip_addr(base, k));
	endfunction

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_reset;
		@(negedge clk);
		if (busy !== 1'b0)
			report_mismatch("reset", "busy", 32'd0, {31'd0, busy});
		if (done !== 1'b0)
			report_mismatch("reset", "done", 32'd0, {31'd0, done});
		if (mem_cmd !== 1'b0)
			report_mismatch("reset", "mem_cmd", 32'd0, {31'd0, mem_cmd});
	endtask

	task automatic test_single_read;
		clear_model_log();
		issue_req(1'b0, ADDR_A, 3'd0, '0);
		wait_done();
		check_read("single_read", ADDR_A, 1, fill_line(ADDR_A));
	endtask

	task automatic test_write_line;
		logic [`MPMC_LINE_W-1:0] line;
		int                      k;
		line = make_line(LINE_SEED);
		clear_model_log();
		issue_req(1'b1, ADDR_D, 3'd7, line);
		wait_done();
		if (cmd_count != 8)
			report_mismatch("write_line", "command count", 32'd8, cmd_count);
		for (k = 0; k < 8 && k < log_addr.size(); k++) begin
			if (log_addr[k] !== strip_addr(ADDR_D, k))
				report_mismatch("write_line", "address", {4'h0, strip_addr(ADDR_D, k)},
					{4'h0, log_addr[k]});
			if (log_we[k] !== 1'b1)
				report_mismatch("write_line", "mem_we", 32'd1, {31'd0, log_we[k]});
			if (log_data[k] !== line[k*32 +: 32])
				report_mismatch("write_line", "mem_wdata", line[k*32 +: 32], log_data[k]);
		end
	endtask

	// The line must come back whole under random stalls and latency
	task automatic test_read_back_stalled;
		clear_model_log();
		stall_en = 1'b1;
		issue_req(1'b0, ADDR_D, 3'd7, '0);
		wait_done();
		stall_en = 1'b0;
		check_read("read_back", ADDR_D, 8, make_line(LINE_SEED));
	endtask

	// A second pulse with other fields lands while the first burst runs
	task automatic test_busy_ignored;
		clear_model_log();
		issue_req(1'b0, ADDR_B, 3'd1, '0);
		@(posedge clk);
		while (mem_cmd !== 1'b1)
			@(posedge clk);
		req        <= 1'b1;
		we         <= 1'b1;
		line_addr  <= ADDR_C;
		num_strips <= 3'd6;
		@(posedge clk);
		// The engine must still report busy when it sees the second pulse
		if (busy !== 1'b1)
			report_mismatch("busy_ignored", "busy", 32'd1, {31'd0, busy});
		req <= 1'b0;
		wait_done();
		repeat (30) @(negedge clk);
		if (done_count != 1)
			report_mismatch("busy_ignored", "done count", 32'd1, done_count);
		check_read("busy_ignored", ADDR_B, 2, fill_line(ADDR_B));
	endtask

	task automatic test_read_four;
		clear_model_log();
		issue_req(1'b0, ADDR_C, 3'd3, '0);
		wait_done();
		check_read("read_four", ADDR_C, 4, fill_line(ADDR_C));
	endtask

	initial begin
		rst_n           = 1'b0;
		req             = 1'b0;
		we              = 1'b0;
		line_addr       = '0;
		num_strips      = '0;
		wline           = '0;
		mem_ready       = 1'b1;
		mem_rd_valid    = 1'b0;
		mem_rd_data     = '0;
		stall_en        = 1'b0;
		lfsr            = 32'hbddb_5d38;
		error_count     = 0;
		cmd_count       = 0;
		done_count      = 0;
		watchdog_cycles = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_single_read();
		test_write_line();
		test_read_back_stalled();
		test_busy_ignored();
		test_read_four();
		$display("Tests run: %0d, errors: %0d", NUM_TESTS, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/mpmc_pkg.sv
hw/mpmc_burst_fsm.sv
hw/mpmc_req_strip_cnt.sv
hw/mpmc_resp_strip_cnt.sv
hw/mpmc_line_buffer.sv
hw/mpmc_burst_engine.sv
verification/tb_mpmc_burst_engine.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -sv
LINT_FLAGS = --lint-only --timing -sv -Wall
TOP        = tb_mpmc_burst_engine
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
